//--- hw/fetch_pkg.sv
package fetch_pkg;

	// One bus word, used for addresses and instructions alike.
	typedef logic [31:0] word_t;

	// Cache line geometry.
	localparam int LINE_WORDS = 8; // Words per line.
	localparam int LINE_OFFSET_BITS = 5; // Byte offset inside a 32-byte line.
	localparam int WORD_SEL_BITS = $clog2(LINE_WORDS); // Word index inside a line.

	// Read burst type codes.
	localparam logic [1:0] BURST_FIXED = 2'b00; // Single beat.
	localparam logic [1:0] BURST_INCR = 2'b01; // Incrementing line refill.

	// Burst length codes, beats minus one.
	localparam logic [3:0] LEN_SINGLE = 4'd0;
	localparam logic [3:0] LEN_LINE = 4'(LINE_WORDS - 1); // Whole line.

endpackage

//--- hw/icache_port_if.sv
`timescale 1ns/1ns

interface icache_port_if import fetch_pkg::*; ();

	// Lookup, answered combinationally by the cache.
	word_t lookup_addr; // Current program counter.
	word_t lookup_data; // Addressed word of the indexed line.
	logic hit; // Tag match on a valid line.

	// Refill, one word per strobe.
	word_t fill_addr;
	word_t fill_data;
	logic fill_valid;

	modport fetch (
		output lookup_addr,
		output fill_addr,
		output fill_data,
		output fill_valid,
		input lookup_data,
		input hit
	);

	modport cache (
		input lookup_addr,
		input fill_addr,
		input fill_data,
		input fill_valid,
		output lookup_data,
		output hit
	);

endinterface

//--- hw/inst_cache.sv
`timescale 1ns/1ns

module inst_cache import fetch_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input logic clock,
	input logic rst_n,
	icache_port_if.cache port
);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_LSB = LINE_OFFSET_BITS + INDEX_BITS;
	localparam int TAG_BITS = 32 - TAG_LSB; // Rest of the address.
	localparam int DATA_BITS = INDEX_BITS + WORD_SEL_BITS; // Data array address width.

	logic [LINES-1:0] valid; // One bit per line.
	logic [TAG_BITS-1:0] tag_mem [LINES];
	word_t data_mem [LINES * LINE_WORDS];

	logic [WORD_SEL_BITS-1:0] fill_cnt; // Words written into the current line.
	logic fill_last;

	// Address fields for lookup.
	logic [INDEX_BITS-1:0] lk_index;
	logic [TAG_BITS-1:0] lk_tag;
	logic [WORD_SEL_BITS-1:0] lk_word;

	// Address fields for refill.
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0] fill_tag;
	logic [WORD_SEL_BITS-1:0] fill_word;

	assign lk_index = port.lookup_addr[TAG_LSB-1:LINE_OFFSET_BITS];
	assign lk_tag = port.lookup_addr[31:TAG_LSB];
	assign lk_word = port.lookup_addr[LINE_OFFSET_BITS-1:2];

	assign fill_index = port.fill_addr[TAG_LSB-1:LINE_OFFSET_BITS];
	assign fill_tag = port.fill_addr[31:TAG_LSB];
	assign fill_word = port.fill_addr[LINE_OFFSET_BITS-1:2];

	// Combinational lookup.
	assign port.hit = valid[lk_index] && (tag_mem[lk_index] == lk_tag);
	assign port.lookup_data = data_mem[DATA_BITS'({lk_index, lk_word})];

	assign fill_last = (fill_cnt == WORD_SEL_BITS'(LINE_WORDS - 1));

	// Beat counter, wraps after a full line.
	always_ff @(posedge clock) begin
		if (!rst_n)
			fill_cnt <= '0;
		else if (port.fill_valid)
			fill_cnt <= fill_cnt + 1'b1;
	end

	// Line valid bits.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (port.fill_valid) begin
			if (fill_last)
				valid[fill_index] <= 1'b1; // Line complete.
			else if (fill_cnt == '0)
				valid[fill_index] <= 1'b0; // Old contents being replaced.
		end
	end

	// Tag and data writes.
	always_ff @(posedge clock) begin
		if (port.fill_valid) begin
			data_mem[DATA_BITS'({fill_index, fill_word})] <= port.fill_data;
			if (fill_last)
				tag_mem[fill_index] <= fill_tag;
		end
	end

endmodule

//--- hw/inst_fetch_unit.sv
`timescale 1ns/1ns

module inst_fetch_unit import fetch_pkg::*; #(
	parameter word_t RESET_PC = 32'h3000_0000,
	parameter word_t CACHE_BASE = 32'ha000_0000,
	parameter word_t CACHE_LIMIT = 32'ha200_0000
) (
	input logic clock,
	input logic rst_n,

	output word_t araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,
	input word_t rdata,
	input logic [1:0] rresp, // Response code is not evaluated.
	input logic rlast,
	input logic rvalid,

	input logic jump_wrong,
	input word_t jump_addr,
	input word_t dnpc,

	output word_t inst,
	output word_t inst_pc,
	output logic idu_valid,
	input logic idu_ready,

	icache_port_if.fetch cache
);

	// One fetch at a time, no overlap with the offer.
	typedef enum logic [2:0] {
		S_START, // Counter loaded, pick cache or bus.
		S_LOOKUP, // Lookup strobe registered, sample hit.
		S_REQ, // Address phase on the bus.
		S_DATA, // Waiting for read beats.
		S_OFFER // Instruction held for the decoder.
	} state_t;

	state_t state;
	word_t pc; // Program counter.
	word_t redirect_pc; // Jump target parked during a bus transfer.
	logic redirect_pend;
	logic [WORD_SEL_BITS-1:0] beat_idx; // Word offset of the current beat.

	logic in_window; // Counter inside cacheable range.
	logic bus_busy;
	logic xfer_done; // Last read beat of the transfer.
	logic beat_hit; // Beat carries the word at pc.
	logic redirect; // Redirect current or parked.
	word_t redirect_target;

	// Window check on the counter.
	assign in_window = (pc >= CACHE_BASE) && (pc < CACHE_LIMIT);

	// Bus request, line aligned for refills.
	assign araddr = in_window ? {pc[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}} : pc;
	assign arvalid = (state == S_REQ);
	assign arburst = in_window ? BURST_INCR : BURST_FIXED;
	assign arlen = in_window ? LEN_LINE : LEN_SINGLE;

	assign bus_busy = (state == S_REQ) || (state == S_DATA);
	assign xfer_done = (state == S_DATA) && rvalid && rlast;
	assign beat_hit = (beat_idx == pc[LINE_OFFSET_BITS-1:2]);

	// A fresh pulse wins over a parked one.
	assign redirect = jump_wrong || redirect_pend;
	assign redirect_target = jump_wrong ? jump_addr : redirect_pc;

	assign cache.lookup_addr = pc; // Stable through START and LOOKUP.

	// Fetch control.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= S_REQ; // Request RESET_PC right away.
			pc <= RESET_PC;
			idu_valid <= 1'b0;
			beat_idx <= '0;
		end else begin
			case (state)
				S_START: begin
					if (jump_wrong) begin
						pc <= jump_addr; // Restart here.
					end else begin
						state <= in_window ? S_LOOKUP : S_REQ;
					end
				end
				S_LOOKUP: begin
					if (jump_wrong) begin
						pc <= jump_addr; // Drop the lookup.
						state <= S_START;
					end else if (cache.hit) begin
						idu_valid <= 1'b1;
						state <= S_OFFER;
					end else begin
						state <= S_REQ; // Miss, refill the line.
					end
				end
				S_REQ: begin
					if (arready) begin
						beat_idx <= '0;
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (rvalid)
						beat_idx <= beat_idx + 1'b1; // Next word of the burst.
					if (xfer_done) begin
						if (redirect) begin
							pc <= redirect_target; // Fetched word is wrong path.
							state <= S_START;
						end else begin
							idu_valid <= 1'b1;
							state <= S_OFFER;
						end
					end
				end
				S_OFFER: begin
					if (jump_wrong) begin
						idu_valid <= 1'b0; // Discard the offer.
						pc <= jump_addr;
						state <= S_START;
					end else if (idu_ready) begin
						idu_valid <= 1'b0;
						pc <= dnpc; // Decoder tells where to go next.
						state <= S_START;
					end
				end
				default: state <= S_START;
			endcase
		end
	end

	// Redirect parking while the bus is busy.
	always_ff @(posedge clock) begin
		if (!rst_n)
			redirect_pend <= 1'b0;
		else if (xfer_done)
			redirect_pend <= 1'b0; // Consumed at transfer end.
		else if (jump_wrong && bus_busy)
			redirect_pend <= 1'b1;
	end

	always_ff @(posedge clock) begin
		if (jump_wrong)
			redirect_pc <= jump_addr; // Latest target wins.
	end

	// Refill strobe to the cache, one cycle behind the beat.
	always_ff @(posedge clock) begin
		if (!rst_n)
			cache.fill_valid <= 1'b0;
		else
			cache.fill_valid <= (state == S_DATA) && rvalid && in_window;
	end

	always_ff @(posedge clock) begin
		if ((state == S_DATA) && rvalid) begin
			cache.fill_data <= rdata;
			cache.fill_addr <= {pc[31:LINE_OFFSET_BITS], beat_idx, 2'b00};
		end
	end

	// Instruction register.
	always_ff @(posedge clock) begin
		if ((state == S_LOOKUP) && cache.hit) begin
			inst <= cache.lookup_data;
			inst_pc <= pc;
		end else if ((state == S_DATA) && rvalid && (beat_hit || !in_window)) begin
			inst <= rdata; // Word at pc, from a single beat or the refill.
			inst_pc <= pc;
		end
	end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
	parameter word_t RESET_PC = 32'h3000_0000,
	parameter word_t CACHE_BASE = 32'ha000_0000, // Cacheable window start.
	parameter word_t CACHE_LIMIT = 32'ha200_0000, // First address past the window.
	parameter int INDEX_BITS = 4 // 16 lines.
) (
	input logic clock,
	input logic rst_n,

	// Read address channel.
	output word_t araddr,
	output logic arvalid,
	input logic arready,
	output logic [1:0] arburst,
	output logic [3:0] arlen,

	// Read data channel, always accepted.
	input word_t rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,

	// Redirect and next address from later stages.
	input logic jump_wrong,
	input word_t jump_addr,
	input word_t dnpc,

	// Decoder side.
	output word_t inst,
	output word_t inst_pc,
	output logic idu_valid,
	input logic idu_ready
);

	icache_port_if cache_bus (); // Lookup and refill path.

	inst_fetch_unit #(
		.RESET_PC(RESET_PC),
		.CACHE_BASE(CACHE_BASE),
		.CACHE_LIMIT(CACHE_LIMIT)
	) u_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.arburst(arburst),
		.arlen(arlen),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.jump_wrong(jump_wrong),
		.jump_addr(jump_addr),
		.dnpc(dnpc),
		.inst(inst),
		.inst_pc(inst_pc),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready),
		.cache(cache_bus.fetch)
	);

	inst_cache #(
		.INDEX_BITS(INDEX_BITS)
	) u_cache (
		.clock(clock),
		.rst_n(rst_n),
		.port(cache_bus.cache)
	);

endmodule

//--- testbench/fetch_top_asserts.sv
`timescale 1ns/1ns

module fetch_top_asserts import fetch_pkg::*; #(
	parameter word_t CACHE_BASE = 32'ha000_0000,
	parameter word_t CACHE_LIMIT = 32'ha200_0000
) (
	input logic clock,
	input logic rst_n,
	input word_t araddr,
	input logic arvalid,
	input logic arready,
	input logic [1:0] arburst,
	input logic [3:0] arlen,
	input word_t inst,
	input word_t inst_pc,
	input logic idu_valid,
	input logic idu_ready,
	input logic jump_wrong
);

	int unsigned hold_fails = 0; // Failure tallies, one per property.
	int unsigned offer_fails = 0;
	int unsigned len_fails = 0;

	logic line_req; // Aligned address inside the window.

	assign line_req = (araddr[LINE_OFFSET_BITS-1:0] == '0)
		&& (araddr >= CACHE_BASE) && (araddr < CACHE_LIMIT);

	// Request stays put until accepted.
	assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arburst)
			&& $stable(arlen))
	else begin
		$error("read request changed before arready");
		hold_fails++;
	end

	// Offer holds under back-pressure.
	assert property (@(posedge clock) disable iff (!rst_n)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(inst)
			&& $stable(inst_pc))
	else begin
		$error("instruction offer changed under back-pressure");
		offer_fails++;
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		arvalid |-> ((arlen == LEN_LINE) == line_req))
	else begin
		$error("burst length does not match the request address");
		len_fails++;
	end

endmodule

bind fetch_top fetch_top_asserts #(
	.CACHE_BASE(CACHE_BASE),
	.CACHE_LIMIT(CACHE_LIMIT)
) u_asserts (
	.clock(clock),
	.rst_n(rst_n),
	.araddr(araddr),
	.arvalid(arvalid),
	.arready(arready),
	.arburst(arburst),
	.arlen(arlen),
	.inst(inst),
	.inst_pc(inst_pc),
	.idu_valid(idu_valid),
	.idu_ready(idu_ready),
	.jump_wrong(jump_wrong)
);

//--- testbench/fetch_top_tb.sv
`timescale 1ns/1ns

module fetch_top_tb import fetch_pkg::*; ();

	localparam word_t RESET_PC = 32'h3000_0000;
	localparam word_t CACHE_BASE = 32'ha000_0000;
	localparam word_t CACHE_LIMIT = 32'ha200_0000;
	localparam int TB_LINES = 16; // Lines in the default geometry.
	localparam int unsigned SEED = 92012;

	// Decoder program keyed on the number of accepted instructions.
	localparam int BRANCH_IN_AT = 5; // Leave the boot region.
	localparam word_t WINDOW_PC = 32'ha000_0010; // Mid-line target.
	localparam int REPLAY_AT = 25; // Jump back into filled lines.
	localparam word_t REPLAY_PC = 32'ha000_0004;
	localparam int REPLAY_END = 41; // Last replayed word is a000_0040.
	localparam int JUMP_A_AT = 45; // Redirect while the bus is busy.
	localparam word_t JUMP_A_PC = 32'h3000_0200;
	localparam int JUMP_B_AT = 52; // Redirect while on offer.
	localparam word_t JUMP_B_PC = 32'ha000_0100;
	localparam int NUM_INST = 64;

	localparam int IDLE_LIMIT = 2000; // Cycles without a bus request.
	localparam int QUIET_LIMIT = 500; // Cycles without a transfer.
	localparam int RUN_LIMIT = 20000;

	logic clock;
	logic rst_n;
	word_t araddr;
	logic arvalid;
	logic arready;
	logic [1:0] arburst;
	logic [3:0] arlen;
	word_t rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic jump_wrong;
	word_t jump_addr;
	word_t dnpc;
	word_t inst;
	word_t inst_pc;
	logic idu_valid;
	logic idu_ready;

	word_t exp_pc_q[$]; // Front is the next address to be delivered.
	int n_acc = 0; // Instructions accepted so far.
	int req_count = 0; // Accepted bus requests.
	int replay_reqs = 0;
	int jumps_done = 0;
	int unsigned mem_rng;
	int unsigned dec_rng;
	word_t line_tag [TB_LINES]; // Line addresses known to be cached.
	bit line_ok [TB_LINES];

	fetch_top u_dut (.*);

	initial begin : clock_gen
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	function automatic int unsigned lcg_step(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Memory content is a fixed scramble of the address.
	function automatic word_t ref_word(input word_t addr);
		word_t mix;
		mix = addr ^ {addr[15:0], addr[31:16]};
		mix = mix * 32'h045d_9f3b;
		return mix ^ 32'h5a5a_0013;
	endfunction

	function automatic bit in_window(input word_t addr);
		return (addr >= CACHE_BASE) && (addr < CACHE_LIMIT);
	endfunction

	function automatic int unsigned protocol_errors();
		return u_dut.u_asserts.hold_fails + u_dut.u_asserts.offer_fails
			+ u_dut.u_asserts.len_fails;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Bus slave with random address and data latency.
	task automatic memory_model();
		int idle;
		int unsigned delay;
		int unsigned beats;
		int unsigned idx;
		word_t base;
		forever begin
			idle = 0;
			while (!arvalid) begin
				@(posedge clock);
				#1;
				idle++;
				if (idle > IDLE_LIMIT)
					abort_run("Timeout: the fetch unit issued no bus request");
			end
			mem_rng = lcg_step(mem_rng);
			delay = (mem_rng >> 16) % 4;
			repeat (delay) begin
				@(posedge clock);
				#1;
			end
			req_count++;
			base = araddr;
			beats = 32'(arlen) + 1;
			if (req_count == 1) begin
				check_value("araddr", araddr, RESET_PC); // Boot fetch.
				check_value("arlen", 32'(arlen), 32'(LEN_SINGLE));
			end
			if (in_window(araddr)) begin
				check_value("araddr[4:0]", 32'(araddr[LINE_OFFSET_BITS-1:0]), 0);
				check_value("arburst", 32'(arburst), 32'(BURST_INCR));
				check_value("arlen", 32'(arlen), 32'(LEN_LINE));
				idx = 32'(araddr[LINE_OFFSET_BITS +: 4]);
				if (line_ok[idx] && (line_tag[idx] == araddr))
					abort_run("Refill requested for a line that is already cached");
				line_ok[idx] = 1'b1; // Burst always runs to the end.
				line_tag[idx] = araddr;
			end else begin
				check_value("arburst", 32'(arburst), 32'(BURST_FIXED));
				check_value("arlen", 32'(arlen), 32'(LEN_SINGLE));
			end
			arready = 1'b1;
			@(posedge clock);
			#1;
			arready = 1'b0;
			for (int unsigned b = 0; b < beats; b++) begin
				mem_rng = lcg_step(mem_rng);
				repeat ((mem_rng >> 16) % 3) begin // Gap before the beat.
					@(posedge clock);
					#1;
				end
				rvalid = 1'b1;
				rdata = ref_word(base + 4 * b);
				rlast = (b + 1 == beats);
				@(posedge clock);
				#1;
				rvalid = 1'b0;
				rlast = 1'b0;
			end
		end
	endtask

	// Planned branch points or the sequential successor.
	function automatic word_t next_pc(input word_t pc, input int n);
		if (n == BRANCH_IN_AT)
			return WINDOW_PC;
		if (n == REPLAY_AT)
			return REPLAY_PC;
		return pc + 32'd4;
	endfunction

	// Decoder with random stalls and two redirects.
	task automatic decoder_model();
		int quiet;
		int unsigned stall;
		quiet = 0;
		stall = 0;
		forever begin
			@(posedge clock);
			#1;
			jump_wrong = 1'b0;
			idu_ready = 1'b0;
			quiet++;
			if (quiet > QUIET_LIMIT)
				abort_run("Timeout: no instruction reached the decoder");
			if (idu_valid && (jumps_done == 1) && (n_acc >= JUMP_B_AT)) begin
				jump_wrong = 1'b1; // Drop the word on offer.
				jump_addr = JUMP_B_PC;
				exp_pc_q = {JUMP_B_PC};
				jumps_done++;
				quiet = 0;
			end else if (!idu_valid && arvalid && (jumps_done == 0) && (n_acc >= JUMP_A_AT)) begin
				jump_wrong = 1'b1; // Fetch in flight is wrong path.
				jump_addr = JUMP_A_PC;
				exp_pc_q = {JUMP_A_PC};
				jumps_done++;
			end else if (idu_valid) begin
				dec_rng = lcg_step(dec_rng);
				if (stall > 0) begin
					stall--;
				end else if ((dec_rng >> 16) % 4 == 0) begin
					stall = (dec_rng >> 20) % 6; // Stretch of back-pressure.
				end else begin
					if (n_acc == REPLAY_AT)
						replay_reqs = req_count;
					if (n_acc == REPLAY_END)
						check_value("request count", req_count, replay_reqs);
					idu_ready = 1'b1;
					dnpc = next_pc(exp_pc_q[0], n_acc); // Successor of the expected address.
					exp_pc_q.push_back(dnpc);
					quiet = 0;
				end
			end
		end
	endtask

	// Every accepted instruction is checked at the falling edge.
	initial begin : transfer_monitor
		forever begin
			@(negedge clock);
			if (protocol_errors() != 0) begin
				abort_run("A protocol assertion failed");
			end else if (rst_n && idu_valid && idu_ready && !jump_wrong) begin
				if (exp_pc_q.size() == 0) begin
					abort_run("An instruction was delivered with no address expected");
				end else begin
					check_value("inst_pc", inst_pc, exp_pc_q[0]);
					check_value("inst", inst, ref_word(exp_pc_q[0]));
					void'(exp_pc_q.pop_front());
					n_acc++;
				end
			end
		end
	end

	initial begin : main_sequence
		int waited;
		rst_n = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		rlast = 1'b0;
		rvalid = 1'b0;
		jump_wrong = 1'b0;
		jump_addr = '0;
		dnpc = '0;
		idu_ready = 1'b0;
		mem_rng = SEED;
		dec_rng = lcg_step(SEED);
		exp_pc_q = {RESET_PC};
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;
		fork
			memory_model();
			decoder_model();
		join_none
		waited = 0;
		while (n_acc < NUM_INST) begin
			@(posedge clock);
			waited++;
			if (waited > RUN_LIMIT)
				abort_run("Timeout: not all instructions were delivered");
		end
		check_value("jumps_done", jumps_done, 2);
		if (protocol_errors() == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			abort_run("A protocol assertion failed");
		end
	end

endmodule

//--- fetch_top.f
hw/fetch_pkg.sv
hw/icache_port_if.sv
hw/inst_cache.sv
hw/inst_fetch_unit.sv
hw/fetch_top.sv
testbench/fetch_top_asserts.sv
testbench/fetch_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch stage testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

TOP=fetch_top_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module "$TOP" --Mdir "$BUILD_DIR" -f fetch_top.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" <<< "$output"; then
	echo "Simulation result: pass"
	exit 0
else
	echo "Simulation result: fail"
	exit 1
fi
